// ==== mmu_pkg.sv ====
package mmu_pkg;

    localparam int unsigned VPN_W    = 20;
    localparam int unsigned PPN_W    = 22;
    localparam int unsigned OFFSET_W = 12;

    // sv32 page table entry with the msb first
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    typedef enum logic [1:0] {
        FAULT_NONE   = 2'd0,
        FAULT_PAGE   = 2'd1,
        FAULT_ACCESS = 2'd2
    } fault_e;

    typedef struct packed {
        logic [VPN_W-1:0]    vpn;
        logic [OFFSET_W-1:0] offset;
    } xlate_req_t;

    // ppn and access are only meaningful with FAULT_NONE
    typedef struct packed {
        fault_e           fault;
        logic [PPN_W-1:0] ppn;
        logic [7:0]       access;
    } walk_result_t;

    typedef struct packed {
        fault_e                    fault;
        logic [PPN_W+OFFSET_W-1:0] paddr;
        logic [7:0]                access;
    } xlate_resp_t;

    typedef enum logic {
        PTW_IDLE,
        PTW_WALK
    } ptw_state_e;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_WALK,
        CTRL_RESPOND
    } ctrl_state_e;

endpackage

// ==== tlb.sv ====
`timescale 1ns/1ps

module tlb #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [mmu_pkg::VPN_W-1:0] lookup_vpn,
    input  logic                      fill,
    input  logic [mmu_pkg::VPN_W-1:0] fill_vpn,
    input  mmu_pkg::walk_result_t     fill_data,
    input  logic                      flush,
    output logic                      hit,
    output mmu_pkg::walk_result_t     entry
);
    import mmu_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);
    localparam int TAG_W = VPN_W - IDX_W;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        walk_result_t     data;
    } tlb_line_t;

    if ((TLB_ENTRIES < 2) || ((TLB_ENTRIES & (TLB_ENTRIES - 1)) != 0)) begin : g_bad_size
        $error("tlb: TLB_ENTRIES must be a power of two, at least 2");
    end

    tlb_line_t              lines [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] valid;

    logic [IDX_W-1:0] lookup_idx;
    logic [TAG_W-1:0] lookup_tag;
    logic [IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] fill_tag;

    // low vpn bits pick the set, the rest is the tag
    assign lookup_idx = lookup_vpn[IDX_W-1:0];
    assign lookup_tag = lookup_vpn[VPN_W-1:IDX_W];
    assign fill_idx   = fill_vpn[IDX_W-1:0];
    assign fill_tag   = fill_vpn[VPN_W-1:IDX_W];

    assign hit   = valid[lookup_idx] && (lines[lookup_idx].tag == lookup_tag);
    assign entry = lines[lookup_idx].data;

    // flush beats a fill in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (fill) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            lines[fill_idx] <= {fill_tag, fill_data};
        end
    end

    // only successful walks get cached
    a_fill_no_fault: assert property (@(posedge clk) disable iff (!rst_n)
        fill |-> fill_data.fault == FAULT_NONE);

endmodule

// ==== page_table_walker.sv ====
`timescale 1ns/1ps

module page_table_walker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      walk_start,
    input  logic [mmu_pkg::VPN_W-1:0] walk_vpn,
    input  logic [mmu_pkg::PPN_W-1:0] walk_root,
    output logic [33:0]               avl_address,
    output logic                      avl_read,
    input  mmu_pkg::pte_t             avl_readdata,
    input  logic                      avl_readdatavalid,
    input  logic                      avl_waitrequest,
    input  logic [1:0]                avl_response,
    output logic                      walk_done,
    output mmu_pkg::walk_result_t     walk_result
);
    import mmu_pkg::*;

    ptw_state_e       state;
    logic             level;
    logic             read_issued;
    logic [PPN_W-1:0] table_base;
    logic [VPN_W-1:0] vpn_q;

    logic       rsp_valid;
    logic       bus_err;
    logic       pte_bad;
    logic       pte_leaf;
    logic       misaligned;
    fault_e     fault;
    logic [PPN_W-1:0] leaf_ppn;
    logic [9:0] vpn_part;

    // level 1 indexes with vpn[19:10], level 0 with vpn[9:0]
    assign vpn_part    = level ? vpn_q[19:10] : vpn_q[9:0];
    assign avl_address = {table_base, vpn_part, 2'b00};
    assign avl_read    = (state == PTW_WALK) && !read_issued;

    // pte decode
    assign rsp_valid  = (state == PTW_WALK) && avl_readdatavalid;
    assign bus_err    = (avl_response != 2'b00);
    assign pte_bad    = !avl_readdata.v || (avl_readdata.w && !avl_readdata.r);
    assign pte_leaf   = avl_readdata.r || avl_readdata.x;
    assign misaligned = level && (avl_readdata.ppn0 != '0);

    // megapage takes the low ppn bits from the vpn
    assign leaf_ppn = level ? {avl_readdata.ppn1, vpn_q[9:0]}
                            : {avl_readdata.ppn1, avl_readdata.ppn0};

    always_comb begin
        walk_done = 1'b0;
        fault     = FAULT_NONE;
        if (rsp_valid) begin
            if (bus_err) begin
                walk_done = 1'b1;
                fault     = FAULT_ACCESS;
            end else if (pte_bad) begin
                walk_done = 1'b1;
                fault     = FAULT_PAGE;
            end else if (pte_leaf) begin
                walk_done = 1'b1;
                if (misaligned) begin
                    fault = FAULT_PAGE;
                end
            end else if (!level) begin
                // pointer where a leaf must be
                walk_done = 1'b1;
                fault     = FAULT_PAGE;
            end
        end
    end

    assign walk_result = '{fault: fault, ppn: leaf_ppn, access: avl_readdata[7:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= PTW_IDLE;
            level       <= 1'b1;
            read_issued <= 1'b0;
        end else begin
            case (state)
                PTW_IDLE: begin
                    if (walk_start) begin
                        state       <= PTW_WALK;
                        level       <= 1'b1;
                        read_issued <= 1'b0;
                    end
                end
                PTW_WALK: begin
                    if (avl_read && !avl_waitrequest) begin
                        read_issued <= 1'b1;
                    end
                    if (walk_done) begin
                        state <= PTW_IDLE;
                    end else if (rsp_valid) begin
                        // level 1 pointer, go one level down
                        level       <= 1'b0;
                        read_issued <= 1'b0;
                    end
                end
                default: state <= PTW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PTW_IDLE && walk_start) begin
            vpn_q      <= walk_vpn;
            table_base <= walk_root;
        end else if (rsp_valid && !walk_done) begin
            table_base <= {avl_readdata.ppn1, avl_readdata.ppn0};
        end
    end

    a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        avl_read && avl_waitrequest |=> avl_read && $stable(avl_address));

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        walk_start |-> state == PTW_IDLE);

endmodule

// ==== translation_ctrl.sv ====
`timescale 1ns/1ps

module translation_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req,
    input  mmu_pkg::xlate_req_t       req_addr,
    input  logic                      satp_mode,
    input  logic [mmu_pkg::PPN_W-1:0] satp_ppn,
    output logic                      busy,
    output logic                      done,
    output mmu_pkg::xlate_resp_t      resp,
    output logic [mmu_pkg::VPN_W-1:0] lookup_vpn,
    input  logic                      tlb_hit,
    input  mmu_pkg::walk_result_t     tlb_entry,
    output logic                      walk_start,
    output logic [mmu_pkg::VPN_W-1:0] walk_vpn,
    output logic [mmu_pkg::PPN_W-1:0] walk_root,
    input  logic                      walk_done,
    input  mmu_pkg::walk_result_t     walk_result,
    output logic                      fill,
    output logic [mmu_pkg::VPN_W-1:0] fill_vpn,
    output mmu_pkg::walk_result_t     fill_data
);
    import mmu_pkg::*;

    ctrl_state_e      state;
    xlate_req_t       req_q;
    logic             mode_q;
    logic [PPN_W-1:0] root_q;
    xlate_resp_t      resp_q;
    xlate_resp_t      lookup_resp;
    xlate_resp_t      walk_resp;
    logic             answer_now;

    // bare mode or a tlb hit answers without walking
    assign answer_now = !mode_q || tlb_hit;

    always_comb begin
        if (!mode_q) begin
            // no pte behind a bare address
            lookup_resp = '{fault: FAULT_NONE, paddr: {2'b00, req_q}, access: 8'h00};
        end else begin
            lookup_resp = '{fault: tlb_entry.fault,
                            paddr: {tlb_entry.ppn, req_q.offset},
                            access: tlb_entry.access};
        end
    end

    assign walk_resp = '{fault: walk_result.fault,
                         paddr: {walk_result.ppn, req_q.offset},
                         access: walk_result.access};

    assign lookup_vpn = req_q.vpn;
    assign walk_start = (state == CTRL_LOOKUP) && !answer_now;
    assign walk_vpn   = req_q.vpn;
    assign walk_root  = root_q;

    assign fill      = (state == CTRL_WALK) && walk_done && (walk_result.fault == FAULT_NONE);
    assign fill_vpn  = req_q.vpn;
    assign fill_data = walk_result;

    assign busy = (state != CTRL_IDLE);
    assign done = (state == CTRL_RESPOND);
    assign resp = resp_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_IDLE;
        end else begin
            case (state)
                CTRL_IDLE:    if (req) state <= CTRL_LOOKUP;
                CTRL_LOOKUP:  state <= answer_now ? CTRL_RESPOND : CTRL_WALK;
                CTRL_WALK:    if (walk_done) state <= CTRL_RESPOND;
                CTRL_RESPOND: state <= CTRL_IDLE;
                default:      state <= CTRL_IDLE;
            endcase
        end
    end

    // request, satp sample and response
    always_ff @(posedge clk) begin
        if (state == CTRL_IDLE && req) begin
            req_q  <= req_addr;
            mode_q <= satp_mode;
            root_q <= satp_ppn;
        end
        if (state == CTRL_LOOKUP && answer_now) begin
            resp_q <= lookup_resp;
        end else if (state == CTRL_WALK && walk_done) begin
            resp_q <= walk_resp;
        end
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !req);

endmodule

// ==== mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req,
    input  mmu_pkg::xlate_req_t       req_addr,
    input  logic                      satp_mode,
    input  logic [mmu_pkg::PPN_W-1:0] satp_ppn,
    input  logic                      flush,
    output logic                      busy,
    output logic                      done,
    output mmu_pkg::xlate_resp_t      resp,
    output logic [33:0]               avl_address,
    output logic                      avl_read,
    input  logic [31:0]               avl_readdata,
    input  logic                      avl_readdatavalid,
    input  logic                      avl_waitrequest,
    input  logic [1:0]                avl_response
);
    import mmu_pkg::*;

    logic [VPN_W-1:0] lookup_vpn;
    logic             tlb_hit;
    walk_result_t     tlb_entry;
    logic             walk_start;
    logic [VPN_W-1:0] walk_vpn;
    logic [PPN_W-1:0] walk_root;
    logic             walk_done;
    walk_result_t     walk_result;
    logic             fill;
    logic [VPN_W-1:0] fill_vpn;
    walk_result_t     fill_data;

    tlb #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_tlb (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_vpn (lookup_vpn),
        .fill       (fill),
        .fill_vpn   (fill_vpn),
        .fill_data  (fill_data),
        .flush      (flush),
        .hit        (tlb_hit),
        .entry      (tlb_entry)
    );

    page_table_walker u_walker (
        .clk               (clk),
        .rst_n             (rst_n),
        .walk_start        (walk_start),
        .walk_vpn          (walk_vpn),
        .walk_root         (walk_root),
        .avl_address       (avl_address),
        .avl_read          (avl_read),
        .avl_readdata      (avl_readdata),
        .avl_readdatavalid (avl_readdatavalid),
        .avl_waitrequest   (avl_waitrequest),
        .avl_response      (avl_response),
        .walk_done         (walk_done),
        .walk_result       (walk_result)
    );

    translation_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_addr    (req_addr),
        .satp_mode   (satp_mode),
        .satp_ppn    (satp_ppn),
        .busy        (busy),
        .done        (done),
        .resp        (resp),
        .lookup_vpn  (lookup_vpn),
        .tlb_hit     (tlb_hit),
        .tlb_entry   (tlb_entry),
        .walk_start  (walk_start),
        .walk_vpn    (walk_vpn),
        .walk_root   (walk_root),
        .walk_done   (walk_done),
        .walk_result (walk_result),
        .fill        (fill),
        .fill_vpn    (fill_vpn),
        .fill_data   (fill_data)
    );

endmodule

// ==== tb_pt_memory.sv ====
`timescale 1ns/1ps

module tb_pt_memory #(
    parameter int          DEPTH    = 1024,
    parameter logic [21:0] BASE_PPN = 22'd1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic [1:0]  latency,
    input  logic [33:0] avl_address,
    input  logic        avl_read,
    output logic [31:0] avl_readdata,
    output logic        avl_readdatavalid,
    output logic        avl_waitrequest,
    output logic [1:0]  avl_response,
    output logic [31:0] read_count
);
    logic [31:0] mem [DEPTH];
    logic        pending;
    logic [1:0]  delay;
    logic [31:0] data_q;
    logic [1:0]  resp_q;
    logic        in_range;

    // the array is the single page at BASE_PPN
    assign in_range        = (avl_address[33:12] == BASE_PPN);
    assign avl_waitrequest = stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending           <= 1'b0;
            delay             <= 2'd0;
            data_q            <= '0;
            resp_q            <= 2'b00;
            read_count        <= '0;
            avl_readdata      <= '0;
            avl_readdatavalid <= 1'b0;
            avl_response      <= 2'b00;
        end else begin
            avl_readdatavalid <= 1'b0;
            if (avl_read && !avl_waitrequest) begin
                pending    <= 1'b1;
                delay      <= latency;
                read_count <= read_count + 1;
                data_q     <= in_range ? mem[avl_address[11:2]] : 32'h0;
                resp_q     <= in_range ? 2'b00 : 2'b10;
            end else if (pending) begin
                if (delay <= 2'd1) begin
                    pending           <= 1'b0;
                    avl_readdatavalid <= 1'b1;
                    avl_readdata      <= data_q;
                    avl_response      <= resp_q;
                end else begin
                    delay <= delay - 2'd1;
                end
            end
        end
    end

endmodule

// ==== tb_mmu_top.sv ====
`timescale 1ns/1ps

module tb_mmu_top;
    import mmu_pkg::*;

    localparam int          TLB_ENTRIES = 4;
    localparam int          TIMEOUT     = 200;
    localparam logic [21:0] ROOT_PPN    = 22'd1;
    localparam logic [21:0] MEM_PPN     = 22'd1;
    localparam logic [31:0] LFSR_SEED   = 32'h417e869c;
    localparam logic [31:0] LFSR_TAPS   = 32'h80200003;

    typedef struct packed {
        logic [31:0] vaddr;
        logic        mode;
        logic        flush;
        logic        walk;
        fault_e      fault;
        logic [33:0] paddr;
        logic [7:0]  access;
        logic [1:0]  reads;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        req;
    xlate_req_t  req_addr;
    logic        satp_mode;
    logic [21:0] satp_ppn;
    logic        flush;
    logic        busy;
    logic        done;
    xlate_resp_t resp;
    logic [33:0] avl_address;
    logic        avl_read;
    logic [31:0] avl_readdata;
    logic        avl_readdatavalid;
    logic        avl_waitrequest;
    logic [1:0]  avl_response;
    logic        stall;
    logic [1:0]  latency;
    logic [31:0] read_count;
    logic [31:0] lfsr;
    pte_t        image [1024];
    row_t        rows [$];

    mmu_top #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .req               (req),
        .req_addr          (req_addr),
        .satp_mode         (satp_mode),
        .satp_ppn          (satp_ppn),
        .flush             (flush),
        .busy              (busy),
        .done              (done),
        .resp              (resp),
        .avl_address       (avl_address),
        .avl_read          (avl_read),
        .avl_readdata      (avl_readdata),
        .avl_readdatavalid (avl_readdatavalid),
        .avl_waitrequest   (avl_waitrequest),
        .avl_response      (avl_response)
    );

    tb_pt_memory #(
        .DEPTH    (1024),
        .BASE_PPN (MEM_PPN)
    ) u_mem (
        .clk               (clk),
        .rst_n             (rst_n),
        .stall             (stall),
        .latency           (latency),
        .avl_address       (avl_address),
        .avl_read          (avl_read),
        .avl_readdata      (avl_readdata),
        .avl_readdatavalid (avl_readdatavalid),
        .avl_waitrequest   (avl_waitrequest),
        .avl_response      (avl_response),
        .read_count        (read_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // memory back-pressure and read latency drawn anew every cycle
    initial begin
        lfsr    = LFSR_SEED;
        stall   = 1'b0;
        latency = 2'd1;
        forever begin
            @(posedge clk);
            #1;
            stall   = (take_bits(2) == 32'd3);
            latency = take_bits(2);
            if (latency == 2'd0) begin
                latency = 2'd1;
            end
        end
    end

    function automatic pte_t make_pte(input logic [11:0] ppn1, input logic [9:0] ppn0,
                                      input logic [7:0] bits);
        return {ppn1, ppn0, 2'b00, bits};
    endfunction

    function automatic logic [31:0] make_vaddr(input logic [9:0] l1, input logic [9:0] l0,
                                               input logic [11:0] off);
        return {l1, l0, off};
    endfunction

    // sv32 walk over the image with one page of memory at MEM_PPN
    function automatic walk_result_t ref_walk(input logic [19:0] vpn, output int reads);
        logic [21:0]  base;
        logic [9:0]   idx;
        pte_t         pte;
        walk_result_t res;
        int           lvl;
        base  = ROOT_PPN;
        reads = 0;
        res   = '{fault: FAULT_PAGE, ppn: '0, access: '0};
        for (lvl = 1; lvl >= 0; lvl--) begin
            idx = (lvl == 1) ? vpn[19:10] : vpn[9:0];
            reads++;
            if (base != MEM_PPN) begin
                res.fault = FAULT_ACCESS;
                return res;
            end
            pte = image[idx];
            if (!pte.v || (pte.w && !pte.r)) begin
                return res;
            end
            if (pte.r || pte.x) begin
                if (lvl == 1 && pte.ppn0 != 10'd0) begin
                    return res;
                end
                res.fault  = FAULT_NONE;
                res.ppn    = (lvl == 1) ? {pte.ppn1, vpn[9:0]} : {pte.ppn1, pte.ppn0};
                res.access = pte[7:0];
                return res;
            end
            base = {pte.ppn1, pte.ppn0};
        end
        // pointer at level 0
        return res;
    endfunction

    task automatic build_image();
        int i;
        // invalid background entries, v stays clear
        for (i = 0; i < 1024; i++) begin
            image[i] = {i[9:0], i[9:0], i[9:0], 2'b00};
        end
        // level 1 entries
        image[10'h001] = make_pte(12'h000, 10'h001, 8'h01);
        image[10'h002] = make_pte(12'h0ab, 10'h000, 8'hcb);
        image[10'h003] = make_pte(12'h0cd, 10'h005, 8'h0f);
        image[10'h004] = make_pte(12'h077, 10'h000, 8'h0e);
        image[10'h005] = make_pte(12'h055, 10'h000, 8'h05);
        image[10'h006] = make_pte(12'h000, 10'h200, 8'h01);
        // level 0 entries
        // the root doubles as the level 0 table
        image[10'h010] = make_pte(12'h123, 10'h045, 8'hd7);
        image[10'h011] = make_pte(12'h000, 10'h001, 8'h01);
        image[10'h014] = make_pte(12'h0fe, 10'h3c1, 8'h4b);
    endtask

    task automatic load_image();
        int i;
        for (i = 0; i < 1024; i++) begin
            u_mem.mem[i] = image[i];
        end
    endtask

    task automatic add_row(input logic [31:0] vaddr, input logic mode, input logic fl,
                           input logic walk);
        row_t         r;
        walk_result_t w;
        int           reads;
        r.vaddr = vaddr;
        r.mode  = mode;
        r.flush = fl;
        r.walk  = walk;
        if (mode) begin
            w        = ref_walk(vaddr[31:12], reads);
            r.fault  = w.fault;
            r.paddr  = {w.ppn, vaddr[11:0]};
            r.access = w.access;
            r.reads  = reads[1:0];
        end else begin
            r.fault  = FAULT_NONE;
            r.paddr  = {2'b00, vaddr};
            r.access = 8'h00;
            r.reads  = 2'd0;
        end
        rows.push_back(r);
    endtask

    task automatic build_rows();
        add_row(make_vaddr(10'h001, 10'h010, 12'h234), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h001, 10'h010, 12'h234), 1'b1, 1'b0, 1'b0);
        add_row(make_vaddr(10'h002, 10'h155, 12'h0ac), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h002, 10'h155, 12'h0ac), 1'b1, 1'b0, 1'b0);
        add_row(make_vaddr(10'h003, 10'h001, 12'h010), 1'b1, 1'b0, 1'b1);
        // faults never reach the tlb, so repeats walk again
        add_row(make_vaddr(10'h004, 10'h020, 12'h000), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h004, 10'h020, 12'h000), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h005, 10'h030, 12'h444), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h001, 10'h011, 12'h008), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h001, 10'h011, 12'h008), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h006, 10'h020, 12'h100), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h006, 10'h020, 12'h100), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h001, 10'h010, 12'h234), 1'b1, 1'b1, 1'b1);
        // 0x410 and 0x414 share tlb index 0
        add_row(make_vaddr(10'h001, 10'h014, 12'habc), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h001, 10'h010, 12'h234), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h001, 10'h014, 12'habc), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h002, 10'h155, 12'h0ac), 1'b1, 1'b0, 1'b1);
        add_row(make_vaddr(10'h002, 10'h155, 12'h0ac), 1'b1, 1'b0, 1'b0);
        add_row(32'hdeadbeef, 1'b0, 1'b0, 1'b0);
        add_row(make_vaddr(10'h001, 10'h010, 12'h234), 1'b0, 1'b0, 1'b0);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic abort_timeout(input string what, input logic [31:0] vaddr);
        $display("timeout after %0d cycles waiting for %s, vaddr %h", TIMEOUT, what, vaddr);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic wait_idle(input logic [31:0] vaddr);
        int cycles;
        cycles = 0;
        while (busy) begin
            if (cycles >= TIMEOUT) begin
                abort_timeout("busy to drop", vaddr);
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic run_row(input row_t r);
        int          cycles;
        logic [31:0] reads_before;
        wait_idle(r.vaddr);
        if (r.flush) begin
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush = 1'b0;
        end
        reads_before = read_count;
        req          = 1'b1;
        req_addr     = r.vaddr;
        satp_mode    = r.mode;
        satp_ppn     = ROOT_PPN;
        @(posedge clk);
        #1;
        req    = 1'b0;
        cycles = 1;
        check_value("busy", busy, 1'b1);
        while (!done) begin
            if (cycles >= TIMEOUT) begin
                abort_timeout("done", r.vaddr);
            end
            @(posedge clk);
            #1;
            cycles++;
            check_value("busy", busy, 1'b1);
        end
        check_value("resp.fault", resp.fault, r.fault);
        if (r.fault == FAULT_NONE) begin
            check_value("resp.paddr", resp.paddr, r.paddr);
            check_value("resp.access", resp.access, r.access);
        end
        check_value("avl_reads", read_count - reads_before, r.walk ? r.reads : 2'd0);
        if (!r.walk) begin
            check_value("done_latency", cycles, 2);
        end
        // done is a single-cycle pulse and busy ends with it
        @(posedge clk);
        #1;
        check_value("done", done, 1'b0);
        check_value("busy", busy, 1'b0);
    endtask

    initial begin
        rst_n     = 1'b0;
        req       = 1'b0;
        req_addr  = '0;
        satp_mode = 1'b0;
        satp_ppn  = '0;
        flush     = 1'b0;
        build_image();
        load_image();
        build_rows();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
mmu_pkg.sv
tlb.sv
page_table_walker.sv
translation_ctrl.sv
mmu_top.sv
tb_pt_memory.sv
tb_mmu_top.sv
